//--- vlog.f
hw/axi_rd_pkg.sv
hw/gaxi_skid_buffer.sv
hw/axi4_master_rd.sv
hw/apb_rd_regs.sv
hw/rd_burst_issue.sv
hw/rd_data_collect.sv
hw/axi_rd_dma_top.sv
verif/axi_rd_slave_model.sv
verif/tb_axi_rd_dma.sv

//--- verif/tb_axi_rd_dma.sv
// Testbench for the APB-controlled AXI4 read engine; memory and stalls come from the slave model
`timescale 1ns/1ps

module tb_axi_rd_dma;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_BURSTS  = 30;
    localparam int BEAT_CYCLES = 5;
    localparam int TIMEOUT_NS  = NUM_BURSTS * (16 * BEAT_CYCLES + 20) * CLK_PERIOD;

    logic                aclk;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [7:0]          paddr;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    axi_rd_pkg::ar_pkt_t m_ar;
    logic                m_arvalid;
    logic                m_arready;
    axi_rd_pkg::r_pkt_t  m_r;
    logic                m_rvalid;
    logic                m_rready;
    logic                busy;
    logic                stall_en;
    axi_rd_pkg::ar_pkt_t ar_log;
    logic [31:0]         seed;
    int                  check_fails;
    int                  fails_at_start;
    int                  tests_run;
    int                  tests_failed;

    axi_rd_dma_top UUT (
        .aclk      (aclk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready),
        .busy      (busy)
    );

    axi_rd_slave_model #(
        .SEED (32'hd125_fc35)
    ) slave (
        .aclk     (aclk),
        .rst      (rst),
        .stall_en (stall_en),
        .ar       (m_ar),
        .arvalid  (m_arvalid),
        .arready  (m_arready),
        .r        (m_r),
        .rvalid   (m_rvalid),
        .rready   (m_rready),
        .ar_log   (ar_log)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h5a5a_0000;
    endfunction

    // Wrapping sum over len+1 consecutive words
    function automatic logic [31:0] expected_sum(input logic [31:0] addr, input logic [7:0] len);
        logic [31:0] acc;
        int          i;
        acc = '0;
        for (i = 0; i <= int'(len); i++) begin
            acc = acc + mem_word(addr + 32'(i) * 32'd4);
        end
        return acc;
    endfunction

    // Setup cycle, then access cycle; sampled a quarter period into the access
    task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge aclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge aclk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = prdata;
        err   = pslverr;
        compare_value("pready in access phase", 32'(pready), 32'd1);
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            check_fails++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic start_burst(input logic [31:0] addr, input logic [7:0] len);
        logic err;
        apb_write(axi_rd_pkg::REG_SRC_ADDR, addr, err);
        compare_value("SRC_ADDR write pslverr", err, 32'd0);
        apb_write(axi_rd_pkg::REG_LEN, 32'(len), err);
        compare_value("LEN write pslverr", err, 32'd0);
        apb_write(axi_rd_pkg::REG_CTRL, 32'd1, err);
        compare_value("CTRL start pslverr", err, 32'd0);
    endtask

    // Polls STATUS.done, then checks results and the AR the slave saw
    task automatic check_burst(input logic [31:0] addr, input logic [7:0] len, input logic err_exp);
        logic [31:0] rd;
        logic        err;
        rd = '0;
        while (!rd[1]) begin
            apb_read(axi_rd_pkg::REG_STATUS, rd, err);
        end
        compare_value("STATUS", rd, {29'd0, err_exp, 2'b10});
        apb_read(axi_rd_pkg::REG_SUM, rd, err);
        compare_value("SUM", rd, expected_sum(addr, len));
        apb_read(axi_rd_pkg::REG_BEATS, rd, err);
        compare_value("BEATS", rd, 32'(len) + 32'd1);
        compare_value("AR addr", ar_log.addr, addr);
        compare_value("AR len", 32'(ar_log.len), 32'(len));
        compare_value("AR burst", 32'(ar_log.burst), 32'd1);
        compare_value("AR size", 32'(ar_log.size), 32'd2);
        compare_value("AR id", 32'(ar_log.id), 32'(axi_rd_pkg::ENGINE_ID));
    endtask

    task automatic run_burst(input logic [31:0] addr, input logic [7:0] len, input logic err_exp);
        start_burst(addr, len);
        check_burst(addr, len, err_exp);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (check_fails != fails_at_start) begin
            tests_failed++;
            $display("Test %s: %0d checks failed", name, check_fails - fails_at_start);
        end else begin
            $display("Test %s: ok", name);
        end
        fails_at_start = check_fails;
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] addr;
        logic [7:0]  len;
        rst            = 1'b1;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        stall_en       = 1'b0;
        seed           = 32'hd125_fc35;
        check_fails    = 0;
        fails_at_start = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (2) @(negedge aclk);
        rst = 1'b0;

        apb_read(axi_rd_pkg::REG_STATUS, rd, err);
        compare_value("STATUS after reset", rd, 32'd0);
        apb_read(axi_rd_pkg::REG_SUM, rd, err);
        compare_value("SUM after reset", rd, 32'd0);
        apb_read(axi_rd_pkg::REG_BEATS, rd, err);
        compare_value("BEATS after reset", rd, 32'd0);
        compare_value("busy after reset", 32'(busy), 32'd0);
        end_test("reset_values");

        run_burst(32'h0000_1000, 8'd0, 1'b0);
        run_burst(32'h0000_2040, 8'd15, 1'b0);
        end_test("basic_bursts");

        // Random page below the error region and a word offset that keeps the burst inside 4 KB
        stall_en = 1'b1;
        repeat (20) begin
            seed = xorshift32(seed);
            len  = 8'(seed[3:0]);
            addr = {1'b0, seed[30:12], 12'h000};
            seed = xorshift32(seed);
            addr = addr | ((seed % (32'd1024 - 32'(len))) << 2);
            run_burst(addr, len, 1'b0);
        end
        end_test("random_bursts_and_ar_fields");

        run_burst(32'hF000_0040, 8'd3, 1'b1);
        run_burst(32'h0000_3000, 8'd2, 1'b0);
        end_test("error_response");

        apb_read(8'h18, rd, err);
        compare_value("pslverr on unmapped offset", 32'(err), 32'd1);
        apb_write(axi_rd_pkg::REG_STATUS, 32'd0, err);
        compare_value("pslverr on STATUS write", 32'(err), 32'd1);
        start_burst(32'h0000_4100, 8'd15);
        apb_write(axi_rd_pkg::REG_CTRL, 32'd1, err);
        compare_value("pslverr on start while busy", 32'(err), 32'd1);
        check_burst(32'h0000_4100, 8'd15, 1'b0);
        end_test("apb_errors");

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, check_fails);
        if (check_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Budget of 30 bursts at 16 slow beats each
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- verif/axi_rd_slave_model.sv
// AXI4 read slave for simulation; one burst at a time, word INCR beats, SLVERR from 0xF000_0000 up
`timescale 1ns/1ps

module axi_rd_slave_model #(
    parameter logic [31:0] SEED = 32'hd125_fc35
) (
    input  logic                aclk,
    input  logic                rst,
    input  logic                stall_en,
    input  axi_rd_pkg::ar_pkt_t ar,
    input  logic                arvalid,
    output logic                arready,
    output axi_rd_pkg::r_pkt_t  r,
    output logic                rvalid,
    input  logic                rready,
    output axi_rd_pkg::ar_pkt_t ar_log
);

    logic                rst_q;
    logic                stall_q;
    logic                ar_fire;
    logic                r_fire;
    axi_rd_pkg::ar_pkt_t ar_q;
    logic                active;
    logic [31:0]         addr;
    logic [31:0]         rnd;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Memory content is computed from the byte address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h5a5a_0000;
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        ar_log  = '0;
        active  = 1'b0;
        addr    = '0;
        rnd     = SEED;
        rst_q   = 1'b1;
        stall_q = 1'b0;
        ar_fire = 1'b0;
        r_fire  = 1'b0;
    end

    // Handshakes taken at the rising edge
    always @(posedge aclk) begin
        rst_q   <= rst;
        stall_q <= stall_en;
        ar_fire <= arvalid && arready;
        r_fire  <= rvalid && rready;
        ar_q    <= ar;
    end

    // Outputs change on the falling edge
    always @(negedge aclk) begin
        rnd = xorshift32(rnd);
        if (rst_q) begin
            active  = 1'b0;
            arready = 1'b0;
            rvalid  = 1'b0;
        end else begin
            if (r_fire) begin
                rvalid = 1'b0;
                addr   = addr + 32'd4;
                if (r.last) begin
                    active = 1'b0;
                end
            end
            if (ar_fire) begin
                active = 1'b1;
                addr   = ar_q.addr;
                ar_log = ar_q;
            end
            // Gaps only between beats, a presented beat is held
            if (active && !rvalid && (!stall_q || rnd[0])) begin
                r.id   = ar_log.id;
                r.data = mem_word(addr);
                r.resp = (addr >= 32'hF000_0000) ? axi_rd_pkg::RESP_SLVERR
                                                 : axi_rd_pkg::RESP_OKAY;
                r.last = (addr == ar_log.addr + {ar_log.len, 2'b00});
                r.user = 1'b0;
                rvalid = 1'b1;
            end
            arready = !active && (!stall_q || rnd[1]);
        end
    end

endmodule

//--- hw/axi_rd_dma_top.sv
// APB-controlled AXI4 read engine; bursts must not cross a 4 KB boundary, no interrupt output
`timescale 1ns/1ps

module axi_rd_dma_top (
    input  logic                              aclk,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [axi_rd_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [axi_rd_pkg::DATA_W-1:0]     pwdata,
    output logic [axi_rd_pkg::DATA_W-1:0]     prdata,
    output logic                              pready,
    output logic                              pslverr,
    output axi_rd_pkg::ar_pkt_t               m_ar,
    output logic                              m_arvalid,
    input  logic                              m_arready,
    input  axi_rd_pkg::r_pkt_t                m_r,
    input  logic                              m_rvalid,
    output logic                              m_rready,
    output logic                              busy
);

    logic                          start;
    logic [axi_rd_pkg::ADDR_W-1:0] src_addr;
    logic [axi_rd_pkg::LEN_W-1:0]  len;
    logic                          burst_open;
    logic                          done_evt;
    logic                          last_seen;
    logic [axi_rd_pkg::DATA_W-1:0] sum;
    logic [axi_rd_pkg::LEN_W:0]    beats;
    logic                          err;
    axi_rd_pkg::ar_pkt_t           fub_ar;
    logic                          fub_arvalid;
    logic                          fub_arready;
    axi_rd_pkg::r_pkt_t            fub_r;
    logic                          fub_rvalid;
    logic                          fub_rready;

    apb_rd_regs u_regs (
        .aclk       (aclk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .burst_open (burst_open),
        .sum        (sum),
        .beats      (beats),
        .err        (err),
        .done_evt   (done_evt),
        .start      (start),
        .src_addr   (src_addr),
        .len        (len)
    );

    rd_burst_issue u_issue (
        .aclk        (aclk),
        .rst         (rst),
        .start       (start),
        .src_addr    (src_addr),
        .len         (len),
        .fub_ar      (fub_ar),
        .fub_arvalid (fub_arvalid),
        .fub_arready (fub_arready),
        .last_seen   (last_seen),
        .burst_open  (burst_open),
        .done_evt    (done_evt)
    );

    axi4_master_rd #(
        .SKID_DEPTH_AR (2),
        .SKID_DEPTH_R  (4)
    ) u_master (
        .aclk        (aclk),
        .rst         (rst),
        .fub_ar      (fub_ar),
        .fub_arvalid (fub_arvalid),
        .fub_arready (fub_arready),
        .fub_r       (fub_r),
        .fub_rvalid  (fub_rvalid),
        .fub_rready  (fub_rready),
        .m_ar        (m_ar),
        .m_arvalid   (m_arvalid),
        .m_arready   (m_arready),
        .m_r         (m_r),
        .m_rvalid    (m_rvalid),
        .m_rready    (m_rready),
        .busy        (busy)
    );

    rd_data_collect u_collect (
        .aclk       (aclk),
        .rst        (rst),
        .burst_open (burst_open),
        .fub_r      (fub_r),
        .fub_rvalid (fub_rvalid),
        .fub_rready (fub_rready),
        .last_seen  (last_seen),
        .sum        (sum),
        .beats      (beats),
        .err        (err)
    );

endmodule

//--- hw/rd_data_collect.sv
// Sums R beats of the open burst; sum wraps at 32 bits, err is sticky until the next start
`timescale 1ns/1ps

module rd_data_collect (
    input  logic                          aclk,
    input  logic                          rst,
    input  logic                          burst_open,
    input  axi_rd_pkg::r_pkt_t            fub_r,
    input  logic                          fub_rvalid,
    output logic                          fub_rready,
    output logic                          last_seen,
    output logic [axi_rd_pkg::DATA_W-1:0] sum,
    output logic [axi_rd_pkg::LEN_W:0]    beats,
    output logic                          err
);

    logic                          open_q;
    logic                          open_rise;
    logic                          accept;
    logic                          beat_bad;
    logic [axi_rd_pkg::DATA_W-1:0] sum_base;
    logic [axi_rd_pkg::LEN_W:0]    beats_base;
    logic                          err_base;

    // Beats outside a burst wait in the R skid buffer
    assign fub_rready = burst_open;
    assign accept     = fub_rvalid && fub_rready;
    assign last_seen  = accept && fub_r.last;
    assign open_rise  = burst_open && !open_q;
    assign beat_bad   = (fub_r.resp != axi_rd_pkg::RESP_OKAY)
                     || (fub_r.id != axi_rd_pkg::ENGINE_ID);

    // New burst starts from zero
    always_comb begin
        sum_base   = open_rise ? '0 : sum;
        beats_base = open_rise ? '0 : beats;
        err_base   = open_rise ? 1'b0 : err;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            open_q <= 1'b0;
            sum    <= '0;
            beats  <= '0;
            err    <= 1'b0;
        end else begin
            open_q <= burst_open;
            if (accept) begin
                sum   <= sum_base + fub_r.data;
                beats <= beats_base + 1'b1;
                err   <= err_base || beat_bad;
            end else if (open_rise) begin
                sum   <= sum_base;
                beats <= beats_base;
                err   <= err_base;
            end
        end
    end

endmodule

//--- hw/rd_burst_issue.sv
// Issues one INCR word burst per start and holds until its last beat; one burst outstanding
`timescale 1ns/1ps

module rd_burst_issue (
    input  logic                          aclk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [axi_rd_pkg::ADDR_W-1:0] src_addr,
    input  logic [axi_rd_pkg::LEN_W-1:0]  len,
    output axi_rd_pkg::ar_pkt_t           fub_ar,
    output logic                          fub_arvalid,
    input  logic                          fub_arready,
    input  logic                          last_seen,
    output logic                          burst_open,
    output logic                          done_evt
);

    axi_rd_pkg::issue_state_e state;

    assign fub_arvalid = (state == axi_rd_pkg::ST_ADDR);
    assign burst_open  = (state != axi_rd_pkg::ST_IDLE);
    assign done_evt    = (state == axi_rd_pkg::ST_WAIT_DATA) && last_seen;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= axi_rd_pkg::ST_IDLE;
        end else begin
            case (state)
                axi_rd_pkg::ST_IDLE: begin
                    if (start) begin
                        state <= axi_rd_pkg::ST_ADDR;
                    end
                end
                axi_rd_pkg::ST_ADDR: begin
                    if (fub_arready) begin
                        state <= axi_rd_pkg::ST_WAIT_DATA;
                    end
                end
                axi_rd_pkg::ST_WAIT_DATA: begin
                    if (last_seen) begin
                        state <= axi_rd_pkg::ST_IDLE;
                    end
                end
                default: state <= axi_rd_pkg::ST_IDLE;
            endcase
        end
    end

    // Request captured at start, held through ADDR
    always_ff @(posedge aclk) begin
        if ((state == axi_rd_pkg::ST_IDLE) && start) begin
            fub_ar       <= '0;
            fub_ar.id    <= axi_rd_pkg::ENGINE_ID;
            fub_ar.addr  <= src_addr;
            fub_ar.len   <= len;
            fub_ar.size  <= axi_rd_pkg::AR_SIZE_WORD;
            fub_ar.burst <= axi_rd_pkg::BURST_INCR;
        end
    end

    // The last beat can only come back after the request has left
    a_last_in_wait: assert property (@(posedge aclk) disable iff (rst)
        last_seen |-> (state == axi_rd_pkg::ST_WAIT_DATA))
        else $error("last beat seen outside WAIT_DATA");

endmodule

//--- hw/apb_rd_regs.sv
// APB register block without wait states; LEN is masked to 16 beats, start is refused while busy
`timescale 1ns/1ps

module apb_rd_regs (
    input  logic                              aclk,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [axi_rd_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [axi_rd_pkg::DATA_W-1:0]     pwdata,
    output logic [axi_rd_pkg::DATA_W-1:0]     prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic                              burst_open,
    input  logic [axi_rd_pkg::DATA_W-1:0]     sum,
    input  logic [axi_rd_pkg::LEN_W:0]        beats,
    input  logic                              err,
    input  logic                              done_evt,
    output logic                              start,
    output logic [axi_rd_pkg::ADDR_W-1:0]     src_addr,
    output logic [axi_rd_pkg::LEN_W-1:0]      len
);

    axi_rd_pkg::reg_addr_e             reg_sel;
    logic                              access;
    logic                              hit;
    logic                              read_only;
    logic                              start_req;
    logic                              start_refused;
    logic                              wr_en;
    logic                              done;
    logic [axi_rd_pkg::DATA_W-1:0]     rdata;

    assign reg_sel = axi_rd_pkg::reg_addr_e'(paddr);
    assign access  = psel && penable;
    assign pready  = 1'b1;

    always_comb begin
        hit       = 1'b1;
        read_only = 1'b0;
        rdata     = '0;
        case (reg_sel)
            axi_rd_pkg::REG_CTRL:     rdata = '0;
            axi_rd_pkg::REG_SRC_ADDR: rdata = src_addr;
            axi_rd_pkg::REG_LEN:      rdata = axi_rd_pkg::DATA_W'(len);
            axi_rd_pkg::REG_STATUS: begin
                read_only = 1'b1;
                rdata     = {{(axi_rd_pkg::DATA_W-3){1'b0}}, err, done, burst_open};
            end
            axi_rd_pkg::REG_SUM: begin
                read_only = 1'b1;
                rdata     = sum;
            end
            axi_rd_pkg::REG_BEATS: begin
                read_only = 1'b1;
                rdata     = axi_rd_pkg::DATA_W'(beats);
            end
            default:                  hit = 1'b0;
        endcase
    end

    // Start pending in the current cycle also counts as busy
    assign start_req     = access && pwrite && (reg_sel == axi_rd_pkg::REG_CTRL) && pwdata[0];
    assign start_refused = start_req && (burst_open || start);
    assign wr_en         = access && pwrite && hit && !read_only && !start_refused;

    assign pslverr = access && (!hit || (pwrite && read_only) || start_refused);
    assign prdata  = (access && !pwrite) ? rdata : '0;

    always_ff @(posedge aclk) begin
        if (rst) begin
            start    <= 1'b0;
            done     <= 1'b0;
            src_addr <= '0;
            len      <= '0;
        end else begin
            start <= wr_en && start_req;
            if (wr_en && (reg_sel == axi_rd_pkg::REG_SRC_ADDR)) begin
                src_addr <= pwdata;
            end
            if (wr_en && (reg_sel == axi_rd_pkg::REG_LEN)) begin
                len <= pwdata[axi_rd_pkg::LEN_W-1:0]
                     & axi_rd_pkg::LEN_W'(axi_rd_pkg::MAX_BEATS - 1);
            end
            if (start) begin
                done <= 1'b0;
            end else if (done_evt) begin
                done <= 1'b1;
            end
        end
    end

    // Busy guard must keep a second burst from being launched
    a_no_start_while_open: assert property (@(posedge aclk) disable iff (rst)
        start |-> !burst_open)
        else $error("start pulsed while a burst is open");

endmodule

//--- hw/axi4_master_rd.sv
// AXI4 read-only master wrapper; AR and R both pass through skid buffers, no write channels
`timescale 1ns/1ps

module axi4_master_rd #(
    parameter int SKID_DEPTH_AR = 2,
    parameter int SKID_DEPTH_R  = 4
) (
    input  logic                aclk,
    input  logic                rst,

    // Front-end side
    input  axi_rd_pkg::ar_pkt_t fub_ar,
    input  logic                fub_arvalid,
    output logic                fub_arready,
    output axi_rd_pkg::r_pkt_t  fub_r,
    output logic                fub_rvalid,
    input  logic                fub_rready,

    // AXI master port
    output axi_rd_pkg::ar_pkt_t m_ar,
    output logic                m_arvalid,
    input  logic                m_arready,
    input  axi_rd_pkg::r_pkt_t  m_r,
    input  logic                m_rvalid,
    output logic                m_rready,

    output logic                busy
);

    localparam int AR_CNT_W = $clog2(SKID_DEPTH_AR + 1);
    localparam int R_CNT_W  = $clog2(SKID_DEPTH_R + 1);

    logic [AR_CNT_W-1:0] ar_count;
    logic [R_CNT_W-1:0]  r_count;

    // Anything buffered or in flight at either edge
    assign busy = (ar_count != '0) || (r_count != '0) || fub_arvalid || m_rvalid;

    gaxi_skid_buffer #(
        .DEPTH      (SKID_DEPTH_AR),
        .DATA_WIDTH ($bits(axi_rd_pkg::ar_pkt_t))
    ) u_ar_skid (
        .aclk     (aclk),
        .rst      (rst),
        .wr_valid (fub_arvalid),
        .wr_ready (fub_arready),
        .wr_data  (fub_ar),
        .rd_valid (m_arvalid),
        .rd_ready (m_arready),
        .rd_data  (m_ar),
        .rd_count (ar_count)
    );

    // Return path, slave to front end
    gaxi_skid_buffer #(
        .DEPTH      (SKID_DEPTH_R),
        .DATA_WIDTH ($bits(axi_rd_pkg::r_pkt_t))
    ) u_r_skid (
        .aclk     (aclk),
        .rst      (rst),
        .wr_valid (m_rvalid),
        .wr_ready (m_rready),
        .wr_data  (m_r),
        .rd_valid (fub_rvalid),
        .rd_ready (fub_rready),
        .rd_data  (fub_r),
        .rd_count (r_count)
    );

endmodule

//--- hw/gaxi_skid_buffer.sv
// Valid/ready circular FIFO; read data comes combinationally from the head entry one cycle after the write
`timescale 1ns/1ps

module gaxi_skid_buffer #(
    parameter int DEPTH      = 2,
    parameter int DATA_WIDTH = 32,
    localparam int PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int CNT_W     = $clog2(DEPTH + 1)
) (
    input  logic                  aclk,
    input  logic                  rst,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic [CNT_W-1:0]      rd_count
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic                  push;
    logic                  pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr_ready = (rd_count != CNT_W'(DEPTH));
    assign rd_valid = (rd_count != '0);
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;
    assign rd_data  = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   rd_count <= rd_count + 1'b1;
                2'b01:   rd_count <= rd_count - 1'b1;
                default: rd_count <= rd_count;
            endcase
        end
    end

    // Storage only
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers meet only when the FIFO is empty or full
    a_no_overflow: assert property (@(posedge aclk) disable iff (rst)
        (rd_count <= CNT_W'(DEPTH))
        && ((wr_ptr == rd_ptr) == ((rd_count == '0) || (rd_count == CNT_W'(DEPTH)))))
        else $error("skid buffer occupancy disagrees with its pointers");

endmodule

//--- hw/axi_rd_pkg.sv
// Shared widths, APB register map and AXI channel structs; 32-bit data only, INCR bursts only
package axi_rd_pkg;

    localparam int ID_W       = 4;
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LEN_W      = 8;
    localparam int APB_ADDR_W = 8;

    // Every burst carries this ID; returned beats are checked against it
    localparam logic [ID_W-1:0] ENGINE_ID = 4'hA;
    localparam int              MAX_BEATS = 16;

    // AR encodings used by the engine
    localparam logic [2:0] AR_SIZE_WORD = 3'd2;
    localparam logic [1:0] BURST_INCR   = 2'b01;

    typedef enum logic [APB_ADDR_W-1:0] {
        REG_CTRL     = 8'h00,
        REG_SRC_ADDR = 8'h04,
        REG_LEN      = 8'h08,
        REG_STATUS   = 8'h0C,
        REG_SUM      = 8'h10,
        REG_BEATS    = 8'h14
    } reg_addr_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WAIT_DATA
    } issue_state_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // Field order follows the AR wire order of the master wrapper
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic              lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
        logic [3:0]        qos;
        logic [3:0]        region;
        logic              user;
    } ar_pkt_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
        logic              user;
    } r_pkt_t;

endpackage
